/* hw/ollarPkg.sv */
// Core-wide widths, flag bit positions, instruction opcodes
// and controller state encoding
`default_nettype none

package ollarPkg;

	localparam int WordWidth = 32;
	localparam int RegCount = 32;

	// Status flag bit positions
	localparam int FlagC = 0;
	localparam int FlagN = 1;
	localparam int FlagV = 2;
	localparam int FlagZ = 3;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [$clog2(RegCount)-1:0] regIndex_t;
	typedef logic [3:0] flags_t;
	typedef logic [7:0] condition_t; // Mask nibble over value nibble

	localparam word_t ResetPc = '0;

	typedef enum logic [7:0]
	{
		OpNop = 8'h00,
		OpJmp = 8'h01,
		OpLd = 8'h02,
		OpSt = 8'h03,
		OpSet = 8'h04,
		OpClr = 8'h05,
		OpCpy = 8'h08,
		OpAdd = 8'h40,
		OpSub = 8'h41,
		OpAnd = 8'h80,
		OpOr = 8'h82,
		OpXor = 8'h84,
		OpNot = 8'h87,
		OpSrl = 8'hC0,
		OpSll = 8'hC1,
		OpSra = 8'hC4,
		OpSlr = 8'hC9
	} opcode_t;

	// One instruction in flight, one bus transfer per fetch or access
	typedef enum logic [1:0]
	{
		FetchInstr,
		FetchImm,
		Execute,
		MemAccess
	} ctrlState_t;

endpackage

`default_nettype wire

/* hw/memBusIf.sv */
// Single memory transfer request between controller and bus master
`timescale 1ns/100ps
`default_nettype none

interface memBusIf;
	logic req; // Held until done
	logic write;
	ollarPkg::word_t address;
	ollarPkg::word_t writeData;
	logic done; // One cycle pulse
	ollarPkg::word_t readData;

	modport controller (output req, write, address, writeData, input done, readData);
	modport master (input req, write, address, writeData, output done, readData);
endinterface

`default_nettype wire

/* hw/busMaster.sv */
// Four-phase req/ack requester between the controller and external memory
`timescale 1ns/100ps
`default_nettype none

module busMaster (
	input logic Clock,
	input logic rstN,
	memBusIf.master bus,
	output logic busReq,
	output logic busWrite,
	output ollarPkg::word_t busAddress,
	output ollarPkg::word_t busWriteData,
	input logic busAck,
	input ollarPkg::word_t busReadData
);

	typedef enum logic [1:0] {Idle, AwaitAck, AwaitRelease} phase_t;

	phase_t phase;
	logic doneReg;
	ollarPkg::word_t readDataReg;
	logic startXfer;

	// Request still high during the done cycle, ignore it there
	assign startXfer = (phase == Idle) && bus.req && !doneReg;

	assign bus.done = doneReg;
	assign bus.readData = readDataReg;

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			phase <= Idle;
			busReq <= 1'b0;
			busWrite <= 1'b0;
			doneReg <= 1'b0;
		end
		else
		begin
			doneReg <= 1'b0;
			case (phase)
				Idle:
				begin
					if (startXfer)
					begin
						busReq <= 1'b1;
						busWrite <= bus.write;
						phase <= AwaitAck;
					end
				end
				AwaitAck:
				begin
					if (busAck)
					begin
						busReq <= 1'b0; // Data captured this edge
						phase <= AwaitRelease;
					end
				end
				AwaitRelease:
				begin
					if (!busAck)
					begin
						busWrite <= 1'b0;
						doneReg <= 1'b1;
						phase <= Idle;
					end
				end
				default: phase <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clock)
	begin
		if (startXfer)
		begin
			busAddress <= bus.address;
			busWriteData <= bus.writeData;
		end
		if ((phase == AwaitAck) && busAck)
			readDataReg <= busReadData; // Valid while ack high
	end

endmodule

`default_nettype wire

/* hw/regFile.sv */
// General register file, two combinational read ports and one write port
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input logic Clock,
	input logic rstN,
	input ollarPkg::regIndex_t readIndexA,
	input ollarPkg::regIndex_t readIndexB,
	output ollarPkg::word_t readDataA,
	output ollarPkg::word_t readDataB,
	input logic writeEnable,
	input ollarPkg::regIndex_t writeIndex,
	input ollarPkg::word_t writeData
);

	ollarPkg::word_t regs [ollarPkg::RegCount];

	assign readDataA = regs[readIndexA];
	assign readDataB = regs[readIndexB];

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < ollarPkg::RegCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
		begin
			regs[writeIndex] <= writeData; // Visible from next cycle
		end
	end

endmodule

`default_nettype wire

/* hw/alu.sv */
// Combinational operation unit, result and new status flags
`timescale 1ns/100ps
`default_nettype none

module alu (
	input ollarPkg::opcode_t opcode,
	input ollarPkg::word_t operandA,
	input ollarPkg::word_t operandB,
	input ollarPkg::flags_t flagsIn,
	output ollarPkg::word_t result,
	output ollarPkg::flags_t flagsOut
);

	logic [ollarPkg::WordWidth:0] sum;
	logic carry;
	logic overflow;
	logic keepFlags;

	assign sum = {1'b0, operandA} + {1'b0, operandB}; // Extra bit is carry out

	always_comb
	begin
		result = operandA;
		carry = 1'b0;
		overflow = 1'b0;
		keepFlags = 1'b0;
		case (opcode)
			ollarPkg::OpAdd:
			begin
				result = sum[ollarPkg::WordWidth-1:0];
				carry = sum[ollarPkg::WordWidth];
				overflow = (operandA[31] == operandB[31]) && (result[31] != operandA[31]);
			end
			ollarPkg::OpSub:
			begin
				result = operandA - operandB;
				carry = operandA >= operandB; // No borrow
				overflow = (operandA[31] != operandB[31]) && (result[31] != operandA[31]);
			end
			ollarPkg::OpAnd: result = operandA & operandB;
			ollarPkg::OpOr: result = operandA | operandB;
			ollarPkg::OpXor: result = operandA ^ operandB;
			ollarPkg::OpNot: result = ~operandA;
			ollarPkg::OpSrl:
			begin
				result = {1'b0, operandA[31:1]};
				carry = operandA[0];
			end
			ollarPkg::OpSll:
			begin
				result = {operandA[30:0], 1'b0};
				carry = operandA[31];
			end
			ollarPkg::OpSra:
			begin
				result = {operandA[31], operandA[31:1]}; // Sign kept
				carry = operandA[0];
			end
			ollarPkg::OpSlr: result = {operandA[30:0], operandA[31]};
			ollarPkg::OpSet: result = operandB;
			ollarPkg::OpCpy: result = operandA;
			ollarPkg::OpLd: result = operandA; // Memory word arrives on A
			ollarPkg::OpClr: result = '0;
			default: keepFlags = 1'b1; // NOP, JMP, ST
		endcase

		if (keepFlags)
		begin
			flagsOut = flagsIn;
		end
		else
		begin
			flagsOut[ollarPkg::FlagC] = carry;
			flagsOut[ollarPkg::FlagN] = result[31];
			flagsOut[ollarPkg::FlagV] = overflow;
			flagsOut[ollarPkg::FlagZ] = result == '0;
		end
	end

endmodule

`default_nettype wire

/* hw/coreControl.sv */
// Instruction sequencing FSM with program counter, status register,
// decode, condition test and operand selection
`timescale 1ns/100ps
`default_nettype none

module coreControl (
	input logic Clock,
	input logic rstN,
	memBusIf.controller bus,
	output ollarPkg::regIndex_t readIndexA,
	output ollarPkg::regIndex_t readIndexB,
	input ollarPkg::word_t readDataA,
	input ollarPkg::word_t readDataB,
	output logic writeEnable,
	output ollarPkg::regIndex_t writeIndex,
	output ollarPkg::word_t writeData,
	output ollarPkg::opcode_t aluOpcode,
	output ollarPkg::word_t aluOperandA,
	output ollarPkg::word_t aluOperandB,
	output ollarPkg::flags_t aluFlagsIn,
	input ollarPkg::word_t aluResult,
	input ollarPkg::flags_t aluFlagsOut
);

	ollarPkg::ctrlState_t state;
	ollarPkg::word_t pc;
	ollarPkg::flags_t status;
	ollarPkg::word_t instr;
	ollarPkg::word_t imm;
	logic memReq;
	logic memWrite;
	ollarPkg::word_t memAddress;
	ollarPkg::word_t memWriteData;

	ollarPkg::opcode_t opcode;
	logic option;
	ollarPkg::condition_t condition;
	logic condPass;
	logic writesReg;
	ollarPkg::word_t offset;
	ollarPkg::word_t effAddress;

	assign opcode = ollarPkg::opcode_t'(instr[31:24]);
	assign option = instr[23];
	assign condition = instr[22:15];

	// Masked flags must match their value bits
	assign condPass = ((status ^ condition[3:0]) & condition[7:4]) == '0;

	assign readIndexA = instr[14:10];
	assign readIndexB = (opcode == ollarPkg::OpSt) ? instr[4:0] : instr[9:5]; // ST reads rD
	assign offset = option ? imm : '0;
	assign effAddress = readDataA + offset;

	assign aluOpcode = opcode;
	assign aluOperandA = (opcode == ollarPkg::OpLd) ? bus.readData : readDataA;
	assign aluOperandB = option ? imm : readDataB;
	assign aluFlagsIn = status;

	always_comb
	begin
		case (opcode)
			ollarPkg::OpSet, ollarPkg::OpClr, ollarPkg::OpCpy,
			ollarPkg::OpAdd, ollarPkg::OpSub, ollarPkg::OpAnd, ollarPkg::OpOr,
			ollarPkg::OpXor, ollarPkg::OpNot, ollarPkg::OpSrl, ollarPkg::OpSll,
			ollarPkg::OpSra, ollarPkg::OpSlr: writesReg = 1'b1;
			default: writesReg = 1'b0;
		endcase
	end

	assign writeIndex = instr[4:0];
	assign writeData = aluResult;
	assign writeEnable = ((state == ollarPkg::Execute) && condPass && writesReg) ||
		((state == ollarPkg::MemAccess) && bus.done && (opcode == ollarPkg::OpLd));

	assign bus.req = memReq;
	assign bus.write = memWrite;
	assign bus.address = memAddress;
	assign bus.writeData = memWriteData;

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= ollarPkg::FetchInstr;
			pc <= ollarPkg::ResetPc;
			status <= '0;
			memReq <= 1'b0;
			memWrite <= 1'b0;
		end
		else
		begin
			case (state)
				ollarPkg::FetchInstr, ollarPkg::FetchImm:
				begin
					if (!memReq)
					begin
						memReq <= 1'b1; // Read of pc
						memWrite <= 1'b0;
					end
					else if (bus.done)
					begin
						memReq <= 1'b0;
						pc <= pc + 1'b1;
						if ((state == ollarPkg::FetchInstr) && bus.readData[23])
							state <= ollarPkg::FetchImm;
						else
							state <= ollarPkg::Execute;
					end
				end
				ollarPkg::Execute:
				begin
					state <= ollarPkg::FetchInstr;
					if (condPass)
					begin
						case (opcode)
							ollarPkg::OpJmp: pc <= effAddress;
							ollarPkg::OpLd, ollarPkg::OpSt:
							begin
								memReq <= 1'b1;
								memWrite <= opcode == ollarPkg::OpSt;
								state <= ollarPkg::MemAccess;
							end
							default:
							begin
								if (writesReg)
									status <= aluFlagsOut;
							end
						endcase
					end
				end
				ollarPkg::MemAccess:
				begin
					if (bus.done)
					begin
						memReq <= 1'b0;
						memWrite <= 1'b0;
						state <= ollarPkg::FetchInstr;
						if (opcode == ollarPkg::OpLd)
						begin
							status[ollarPkg::FlagN] <= aluFlagsOut[ollarPkg::FlagN];
							status[ollarPkg::FlagZ] <= aluFlagsOut[ollarPkg::FlagZ];
						end
					end
				end
				default: state <= ollarPkg::FetchInstr;
			endcase
		end
	end

	always_ff @(posedge Clock)
	begin
		if (((state == ollarPkg::FetchInstr) || (state == ollarPkg::FetchImm)) && !memReq)
			memAddress <= pc;
		if ((state == ollarPkg::FetchInstr) && memReq && bus.done)
			instr <= bus.readData;
		if ((state == ollarPkg::FetchImm) && memReq && bus.done)
			imm <= bus.readData;
		if (state == ollarPkg::Execute)
		begin
			memAddress <= effAddress; // Used only by LD and ST
			memWriteData <= readDataB;
		end
	end

endmodule

`default_nettype wire

/* hw/ollarCore.sv */
// Core top level, controller, register file, ALU and memory bus master
`timescale 1ns/100ps
`default_nettype none

module ollarCore (
	input logic Clock,
	input logic rstN,
	output logic busReq,
	output logic busWrite,
	output ollarPkg::word_t busAddress,
	output ollarPkg::word_t busWriteData,
	input logic busAck,
	input ollarPkg::word_t busReadData
);

	ollarPkg::regIndex_t readIndexA;
	ollarPkg::regIndex_t readIndexB;
	ollarPkg::regIndex_t writeIndex;
	ollarPkg::word_t readDataA;
	ollarPkg::word_t readDataB;
	ollarPkg::word_t writeData;
	logic writeEnable;
	ollarPkg::opcode_t aluOpcode;
	ollarPkg::word_t aluOperandA;
	ollarPkg::word_t aluOperandB;
	ollarPkg::word_t aluResult;
	ollarPkg::flags_t aluFlagsIn;
	ollarPkg::flags_t aluFlagsOut;

	memBusIf memBus ();

	coreControl control (
		.Clock, .rstN, .bus(memBus.controller),
		.readIndexA, .readIndexB, .readDataA, .readDataB,
		.writeEnable, .writeIndex, .writeData,
		.aluOpcode, .aluOperandA, .aluOperandB, .aluFlagsIn, .aluResult, .aluFlagsOut
	);

	regFile registers (
		.Clock, .rstN, .readIndexA, .readIndexB, .readDataA, .readDataB,
		.writeEnable, .writeIndex, .writeData
	);

	alu opUnit (
		.opcode(aluOpcode), .operandA(aluOperandA), .operandB(aluOperandB),
		.flagsIn(aluFlagsIn), .result(aluResult), .flagsOut(aluFlagsOut)
	);

	busMaster master (
		.Clock, .rstN, .bus(memBus.master),
		.busReq, .busWrite, .busAddress, .busWriteData, .busAck, .busReadData
	);

endmodule

`default_nettype wire

/* dv/tbMemory.sv */
// Testbench memory answering four-phase requests after a random ack delay
// and recording every write
`timescale 1ns/100ps
`default_nettype none

module tbMemory (
	input logic Clock,
	input logic rstN,
	input logic busReq,
	input logic busWrite,
	input ollarPkg::word_t busAddress,
	input ollarPkg::word_t busWriteData,
	output logic busAck,
	output ollarPkg::word_t busReadData,
	output logic writeSeen,
	output ollarPkg::word_t writeAddress,
	output ollarPkg::word_t writeData
);

	ollarPkg::word_t words [256]; // Program and data loaded by the testbench
	int seed = 32'h921d;
	int delay = 0;
	logic pending = 1'b0;

	initial
	begin
		busAck <= 1'b0;
		busReadData <= '0;
	end

	// Responses change on the falling edge away from the core's sampling edge
	always @(negedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			busAck <= 1'b0;
			writeSeen <= 1'b0;
			pending = 1'b0;
		end
		else
		begin
			writeSeen <= 1'b0;
			if (busAck)
			begin
				if (!busReq)
					busAck <= 1'b0; // Release after the core lets go
			end
			else if (busReq)
			begin
				if (!pending)
				begin
					pending = 1'b1;
					delay = $random(seed) & 3; // 0 to 3 cycles
				end
				if (delay == 0)
				begin
					pending = 1'b0;
					busAck <= 1'b1;
					if (busWrite)
					begin
						words[busAddress[7:0]] <= busWriteData;
						writeSeen <= 1'b1; // One cycle pulse for the next rising edge
						writeAddress <= busAddress;
						writeData <= busWriteData;
					end
					else
						busReadData <= words[busAddress[7:0]];
				end
				else
					delay = delay - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* dv/ollarCoreTb.sv */
// Core testbench with the test program, expected stores, store checker,
// clock, reset and timeout
`timescale 1ns/100ps
`default_nettype none

module ollarCoreTb;

	localparam ollarPkg::word_t ValueA = 32'h1234_5678;
	localparam ollarPkg::word_t ValueB = 32'h0F0F_00FF;
	localparam ollarPkg::word_t ValueS = 32'h8000_0003; // Sign and low bits for shifts
	localparam ollarPkg::word_t ValueD = 32'hA5C3_0F96; // Negative LD data
	localparam int ResetCycles = 16;
	localparam int CyclesPerWord = 20;

	logic Clock = 1'b0;
	logic rstN = 1'b0;
	logic busReq;
	logic busWrite;
	logic busAck;
	logic writeSeen;
	ollarPkg::word_t busAddress;
	ollarPkg::word_t busWriteData;
	ollarPkg::word_t busReadData;
	ollarPkg::word_t writeAddress;
	ollarPkg::word_t writeData;

	ollarPkg::word_t code [$]; // Program image from address 0
	string expName [$];
	ollarPkg::word_t expAddress [$];
	ollarPkg::word_t expData [$];
	int cycleLimit = 0;
	int cycleCount = 0;
	int jumpImm;
	int loadImm;

	ollarCore UUT (
		.Clock, .rstN, .busReq, .busWrite, .busAddress, .busWriteData, .busAck, .busReadData
	);

	tbMemory memory (
		.Clock, .rstN, .busReq, .busWrite, .busAddress, .busWriteData, .busAck, .busReadData,
		.writeSeen, .writeAddress, .writeData
	);

	always #2 Clock = ~Clock;

	always @(posedge Clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Error: the core stopped making memory requests, no result after %0d cycles",
				cycleLimit);
			$display("Test FAILED");
			$fatal(1, "Timeout");
		end
	end

	task automatic checkValue(input string name, input ollarPkg::word_t expected,
		input ollarPkg::word_t actual);
		if (expected !== actual)
		begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Register operands only
	task automatic emit(input ollarPkg::opcode_t op, input ollarPkg::condition_t cond,
		input int ra, input int rb, input int rd);
		code.push_back({op, 1'b0, cond, ra[4:0], rb[4:0], rd[4:0]});
	endtask

	// Option set and the immediate word follows
	task automatic emitWithImm(input ollarPkg::opcode_t op, input ollarPkg::condition_t cond,
		input int ra, input int rd, input ollarPkg::word_t imm);
		code.push_back({op, 1'b1, cond, ra[4:0], 5'd0, rd[4:0]});
		code.push_back(imm);
	endtask

	// ST of rd to an absolute address and the store it must produce
	task automatic storeAndExpect(input int rd, input ollarPkg::word_t address, input string name,
		input ollarPkg::word_t data);
		emitWithImm(ollarPkg::OpSt, 8'h00, 0, rd, address);
		expName.push_back(name);
		expAddress.push_back(address);
		expData.push_back(data);
	endtask

	initial
	begin
		emitWithImm(ollarPkg::OpSet, 8'h00, 0, 1, ValueA);
		emitWithImm(ollarPkg::OpSet, 8'h00, 0, 2, ValueB);
		emitWithImm(ollarPkg::OpSet, 8'h00, 0, 12, ValueS);
		storeAndExpect(1, 32'h80, "SET and ST", ValueA);
		emit(ollarPkg::OpAdd, 8'h00, 1, 2, 3);
		storeAndExpect(3, 32'h81, "ADD", ValueA + ValueB);
		emit(ollarPkg::OpSub, 8'h00, 1, 2, 4);
		storeAndExpect(4, 32'h82, "SUB", ValueA - ValueB);
		emit(ollarPkg::OpAnd, 8'h00, 1, 2, 5);
		storeAndExpect(5, 32'h83, "AND", ValueA & ValueB);
		emit(ollarPkg::OpOr, 8'h00, 1, 2, 6);
		storeAndExpect(6, 32'h84, "OR", ValueA | ValueB);
		emit(ollarPkg::OpXor, 8'h00, 1, 2, 7);
		storeAndExpect(7, 32'h85, "XOR", ValueA ^ ValueB);
		emit(ollarPkg::OpNot, 8'h00, 1, 0, 8);
		storeAndExpect(8, 32'h86, "NOT", ~ValueA);
		emit(ollarPkg::OpSrl, 8'h00, 12, 0, 9);
		storeAndExpect(9, 32'h87, "SRL", ValueS >> 1);
		emit(ollarPkg::OpSll, 8'h00, 12, 0, 10);
		storeAndExpect(10, 32'h88, "SLL", ValueS << 1);
		emit(ollarPkg::OpSra, 8'h00, 12, 0, 11);
		storeAndExpect(11, 32'h89, "SRA", ollarPkg::word_t'($signed(ValueS) >>> 1));
		emit(ollarPkg::OpSlr, 8'h00, 12, 0, 13);
		storeAndExpect(13, 32'h8A, "SLR", (ValueS << 1) | (ValueS >> 31));

		// Overflow gives exactly N and V
		emitWithImm(ollarPkg::OpSet, 8'h00, 0, 14, 32'h7FFF_FFFF);
		emitWithImm(ollarPkg::OpSet, 8'h00, 0, 15, 32'h1);
		emit(ollarPkg::OpAdd, 8'h00, 14, 15, 16);
		emitWithImm(ollarPkg::OpSet, 8'h40, 0, 17, 32'h11); // Needs V clear
		emitWithImm(ollarPkg::OpSet, 8'hF6, 0, 18, 32'h22); // Needs N and V only
		storeAndExpect(16, 32'h8B, "ADD overflow", 32'h8000_0000);
		storeAndExpect(17, 32'h8C, "skip on V clear", 32'h0);
		storeAndExpect(18, 32'h8D, "run on N and V", 32'h22);

		// Equal operands give Z and C
		emit(ollarPkg::OpSub, 8'h00, 15, 15, 19);
		emitWithImm(ollarPkg::OpSet, 8'h80, 0, 20, 32'h33); // Needs Z clear
		emitWithImm(ollarPkg::OpSet, 8'hF9, 0, 21, 32'h44); // Needs Z and C only
		storeAndExpect(20, 32'h8E, "skip on Z clear", 32'h0);
		storeAndExpect(21, 32'h8F, "run on Z and C", 32'h44);

		emitWithImm(ollarPkg::OpLd, 8'h00, 0, 22, 32'h0);
		loadImm = code.size() - 1;
		emitWithImm(ollarPkg::OpSet, 8'hF2, 0, 24, 32'h55); // N from the loaded word
		emit(ollarPkg::OpCpy, 8'h00, 22, 0, 23);
		emit(ollarPkg::OpClr, 8'h00, 0, 0, 22);
		storeAndExpect(24, 32'h90, "run on N after LD", 32'h55);
		storeAndExpect(22, 32'h91, "CLR", 32'h0);
		storeAndExpect(23, 32'h92, "LD and CPY", ValueD);

		emitWithImm(ollarPkg::OpJmp, 8'h00, 0, 0, 32'h0);
		jumpImm = code.size() - 1;
		emitWithImm(ollarPkg::OpSt, 8'h00, 0, 1, 32'h93); // Jumped over
		code[jumpImm] = code.size();
		storeAndExpect(2, 32'h94, "JMP target", ValueB);
		emitWithImm(ollarPkg::OpJmp, 8'h00, 0, 0, code.size()); // Parks the core
		code[loadImm] = code.size();
		code.push_back(ValueD);

		cycleLimit = ResetCycles + code.size() * CyclesPerWord;
		for (int i = 0; i < code.size(); i++)
			memory.words[i[7:0]] = code[i];

		repeat (ResetCycles) @(negedge Clock);
		checkValue("no request during reset", 32'h0, ollarPkg::word_t'(busReq));
		rstN <= 1'b1;
		while (!busReq)
			@(negedge Clock);
		checkValue("first fetch address", 32'h0, busAddress);

		for (int n = 0; n < expName.size(); n++)
		begin
			@(posedge Clock);
			while (!writeSeen)
				@(posedge Clock);
			checkValue({expName[n], " address"}, expAddress[n], writeAddress);
			checkValue({expName[n], " data"}, expData[n], writeData);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/ollarPkg.sv
hw/memBusIf.sv
hw/busMaster.sv
hw/regFile.sv
hw/alu.sv
hw/coreControl.sv
hw/ollarCore.sv
dv/tbMemory.sv
dv/ollarCoreTb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module ollarCoreTb -f all.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "Test FAILED: build or simulation error" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
